//--- src/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// channel count and the width of address and word-count registers
`define DMA_CHANNELS 4
`define DMA_ADDR_WIDTH 16

// cpu register map, 4-bit address
// addresses 0..7 hold channel address (even) and count (odd)
`define DMA_REG_CHAN_LAST 4'd7
`define DMA_REG_COMMAND 4'd8
`define DMA_REG_MASK 4'd10
`define DMA_REG_MODE 4'd11
`define DMA_REG_CLEAR_FF 4'd12

// single mask write layout
`define DMA_MASK_SET_BIT 2

`endif

//--- src/dmaPkg.sv
`include "dma_settings.svh"

package dmaPkg;

  // one-hot transfer states, S3 is never used
  typedef enum logic [4:0] {
    SI = 5'b00001,
    SO = 5'b00010,
    S1 = 5'b00100,
    S2 = 5'b01000,
    S4 = 5'b10000
  } dmaState_e;

  typedef enum logic [1:0] {
    XFER_VERIFY = 2'b00,
    XFER_WRITE  = 2'b01,
    XFER_READ   = 2'b10
  } xferType_e;

  typedef struct packed {
    logic       wrStrobe;
    logic [3:0] addr;
    logic [7:0] data;
  } cpuAccess_t;

  // only bit 4 and bit 2 have a meaning here
  typedef struct packed {
    logic [2:0] reservedHigh;
    logic       rotatingPriority;
    logic       reservedMid;
    logic       controllerDisable;
    logic [1:0] reservedLow;
  } commandFields_t;

  typedef struct packed {
    logic [1:0] modeSel;
    logic       addrDecrement;
    logic       autoInit;
    xferType_e  xferType;
    logic [1:0] channelSel;
  } modeFields_t;

  // the register address picks which view is valid
  typedef union packed {
    commandFields_t command;
    modeFields_t    mode;
  } cpuDataWord_u;

  typedef struct packed {
    xferType_e xferType;
    logic      autoInit;
    logic      addrDecrement;
  } chanSetup_t;

  typedef struct packed {
    logic                       hrq;
    logic                       aen;
    logic                       adstb;
    logic [`DMA_CHANNELS-1:0]   dack;
    logic                       iorN;
    logic                       iowN;
    logic                       memrN;
    logic                       memwN;
    logic [`DMA_ADDR_WIDTH-1:0] address;
  } busCycle_t;

endpackage

//--- src/dmaRegisterFile.sv
`include "dma_settings.svh"

module dmaRegisterFile import dmaPkg::*; (
  input  logic                                   busIf,
  input  logic                                   rstN,
  input  cpuAccess_t                             cpu,
  input  logic [`DMA_CHANNELS-1:0]               tcReached,
  input  logic [1:0]                             servedChan,
  output chanSetup_t [`DMA_CHANNELS-1:0]         setup,
  output logic [`DMA_CHANNELS-1:0]               mask,
  output commandFields_t                         command,
  output logic [`DMA_CHANNELS-1:0]               loadAddr,
  output logic [`DMA_CHANNELS-1:0]               loadCount,
  output logic [`DMA_ADDR_WIDTH-1:0]             loadValue,
  output logic [`DMA_CHANNELS-1:0]               tcFlags
);

  cpuDataWord_u dataWord;
  logic         byteFlipFlop;
  logic [7:0]   lowByte;
  logic         chanWrite;
  logic         highByteWrite;
  logic [1:0]   regChan;
  logic         commandWrite;
  logic         modeWrite;
  logic         maskWrite;
  logic         clearFlipFlop;

  assign dataWord = cpu.data;
  assign regChan = cpu.addr[2:1];

  // register decode
  assign chanWrite = cpu.wrStrobe && (cpu.addr <= `DMA_REG_CHAN_LAST);
  assign commandWrite = cpu.wrStrobe && (cpu.addr == `DMA_REG_COMMAND);
  assign modeWrite = cpu.wrStrobe && (cpu.addr == `DMA_REG_MODE);
  assign maskWrite = cpu.wrStrobe && (cpu.addr == `DMA_REG_MASK);
  assign clearFlipFlop = cpu.wrStrobe && (cpu.addr == `DMA_REG_CLEAR_FF);

  // second byte of a pair completes the 16-bit value
  assign highByteWrite = chanWrite && byteFlipFlop;
  assign loadValue = {cpu.data, lowByte};

  always_comb begin
    loadAddr = '0;
    loadCount = '0;
    if (highByteWrite) begin
      if (cpu.addr[0]) begin
        loadCount[regChan] = 1'b1;
      end else begin
        loadAddr[regChan] = 1'b1;
      end
    end
  end

  always_ff @(posedge busIf) begin
    if (chanWrite && !byteFlipFlop) begin
      lowByte <= cpu.data;
    end
  end

  always_ff @(posedge busIf) begin
    if (!rstN) begin
      byteFlipFlop <= 1'b0;
      command <= '0;
      setup <= '0;
      mask <= '1;
      tcFlags <= '0;
    end else begin
      if (chanWrite) begin
        byteFlipFlop <= !byteFlipFlop;
      end else if (clearFlipFlop) begin
        byteFlipFlop <= 1'b0;
      end

      if (commandWrite) begin
        command <= dataWord.command;
      end

      if (modeWrite) begin
        setup[dataWord.mode.channelSel] <= '{xferType: dataWord.mode.xferType,
                                             autoInit: dataWord.mode.autoInit,
                                             addrDecrement: dataWord.mode.addrDecrement};
      end

      // a new count clears the old terminal count flag
      tcFlags <= (tcFlags & ~loadCount) | tcReached;

      // without auto-init the channel stops itself at terminal count
      if (|tcReached && !setup[servedChan].autoInit) begin
        mask[servedChan] <= 1'b1;
      end
      // cpu mask write wins over the TC mask
      if (maskWrite) begin
        mask[cpu.data[1:0]] <= cpu.data[`DMA_MASK_SET_BIT];
      end
    end
  end

endmodule

//--- src/dmaPriority.sv
`include "dma_settings.svh"

module dmaPriority (
  input  logic                     busIf,
  input  logic                     rstN,
  input  logic [`DMA_CHANNELS-1:0] request,
  input  logic                     rotating,
  input  logic                     serviced,
  input  logic [1:0]               servedChan,
  output logic [`DMA_CHANNELS-1:0] grant,
  output logic                     anyRequest
);

  localparam int ChanBits = $clog2(`DMA_CHANNELS);

  logic [ChanBits-1:0] lowestPri;
  logic [ChanBits-1:0] firstChan;
  logic [ChanBits-1:0] probe;
  logic                found;

  // pointer names the lowest-priority channel, reset makes channel 0 highest
  always_ff @(posedge busIf) begin
    if (!rstN) begin
      lowestPri <= '1;
    end else if (serviced && rotating) begin
      lowestPri <= servedChan;
    end
  end

  assign firstChan = rotating ? lowestPri + 1'b1 : '0;
  assign anyRequest = |request;

  // scan upward from the highest-priority channel, wrapping around
  always_comb begin
    grant = '0;
    found = 1'b0;
    probe = firstChan;
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      probe = firstChan + ChanBits'(i);
      if (!found && request[probe]) begin
        grant[probe] = 1'b1;
        found = 1'b1;
      end
    end
  end

endmodule

//--- src/dmaAddressCounter.sv
`include "dma_settings.svh"

module dmaAddressCounter import dmaPkg::*; (
  input  logic                       busIf,
  input  logic                       rstN,
  input  logic [`DMA_CHANNELS-1:0]   loadAddr,
  input  logic [`DMA_CHANNELS-1:0]   loadCount,
  input  logic [`DMA_ADDR_WIDTH-1:0] loadValue,
  input  logic                       update,
  input  logic [1:0]                 servedChan,
  input  chanSetup_t                 setup,
  output logic [`DMA_ADDR_WIDTH-1:0] address,
  output logic [`DMA_CHANNELS-1:0]   tcReached
);

  logic [`DMA_ADDR_WIDTH-1:0] baseAddr  [`DMA_CHANNELS];
  logic [`DMA_ADDR_WIDTH-1:0] curAddr   [`DMA_CHANNELS];
  logic [`DMA_ADDR_WIDTH-1:0] baseCount [`DMA_CHANNELS];
  logic [`DMA_ADDR_WIDTH-1:0] curCount  [`DMA_CHANNELS];
  logic                       countDone;

  assign address = curAddr[servedChan];

  // count was zero before this step, so it wraps now
  assign countDone = (curCount[servedChan] == '0);

  always_comb begin
    tcReached = '0;
    if (update && countDone) begin
      tcReached[servedChan] = 1'b1;
    end
  end

  always_ff @(posedge busIf) begin
    if (!rstN) begin
      for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
        baseAddr[ch] <= '0;
        curAddr[ch] <= '0;
        baseCount[ch] <= '0;
        curCount[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < `DMA_CHANNELS; ch++) begin
        if (update && (servedChan == 2'(ch))) begin
          if (countDone && setup.autoInit) begin
            curAddr[ch] <= baseAddr[ch];
            curCount[ch] <= baseCount[ch];
          end else begin
            curAddr[ch] <= setup.addrDecrement ? curAddr[ch] - 1'b1 : curAddr[ch] + 1'b1;
            curCount[ch] <= curCount[ch] - 1'b1;
          end
        end
        // cpu programming overrides a step in the same cycle
        if (loadAddr[ch]) begin
          baseAddr[ch] <= loadValue;
          curAddr[ch] <= loadValue;
        end
        if (loadCount[ch]) begin
          baseCount[ch] <= loadValue;
          curCount[ch] <= loadValue;
        end
      end
    end
  end

endmodule

//--- src/dmaTimingControl.sv
`include "dma_settings.svh"

module dmaTimingControl import dmaPkg::*; (
  input  logic                       busIf,
  input  logic                       rstN,
  input  logic                       anyRequest,
  input  logic [`DMA_CHANNELS-1:0]   grant,
  input  logic                       hlda,
  input  chanSetup_t                 setup,
  input  logic [`DMA_ADDR_WIDTH-1:0] address,
  output busCycle_t                  bus,
  output logic                       update,
  output logic [1:0]                 servedChan
);

  dmaState_e                state;
  dmaState_e                nextState;
  logic [`DMA_CHANNELS-1:0] grantHold;
  logic                     writeXfer;
  logic                     readXfer;

  always_ff @(posedge busIf) begin
    if (!rstN) begin
      state <= SI;
      grantHold <= '0;
    end else begin
      state <= nextState;
      // grant stays frozen until the transfer ends
      if (state == SI && anyRequest) begin
        grantHold <= grant;
      end
    end
  end

  always_comb begin
    case (state)
      SI: nextState = anyRequest ? SO : SI;
      SO: nextState = hlda ? S1 : SO;
      S1: nextState = S2;
      S2: nextState = S4;
      S4: nextState = SI;
      default: nextState = SI;
    endcase
  end

  always_comb begin
    servedChan = '0;
    for (int i = 0; i < `DMA_CHANNELS; i++) begin
      if (grantHold[i]) begin
        servedChan = 2'(i);
      end
    end
  end

  assign update = (state == S4);
  assign writeXfer = (setup.xferType == XFER_WRITE);
  assign readXfer = (setup.xferType == XFER_READ);

  // fly-by cycle, device side strobe pairs with the opposite memory strobe
  always_comb begin
    bus = '0;
    bus.iorN = 1'b1;
    bus.iowN = 1'b1;
    bus.memrN = 1'b1;
    bus.memwN = 1'b1;
    bus.hrq = (state != SI);
    bus.aen = state inside {S1, S2, S4};
    bus.adstb = (state == S1);
    if (bus.aen) begin
      bus.address = address;
    end
    if (state inside {S2, S4}) begin
      bus.dack = grantHold;
      bus.iorN = !writeXfer;
      bus.memrN = !readXfer;
    end
    // verify asserts no strobe at all
    if (state == S4) begin
      bus.memwN = !writeXfer;
      bus.iowN = !readXfer;
    end
  end

endmodule

//--- src/dmaController.sv
`include "dma_settings.svh"

module dmaController import dmaPkg::*; (
  input  logic                     busIf,
  input  logic                     rstN,
  input  cpuAccess_t               cpu,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic                     hlda,
  output busCycle_t                bus,
  output logic [7:0]               status
);

  chanSetup_t [`DMA_CHANNELS-1:0] setup;
  chanSetup_t                     servedSetup;
  commandFields_t                 command;
  logic [`DMA_CHANNELS-1:0]       mask;
  logic [`DMA_CHANNELS-1:0]       loadAddr;
  logic [`DMA_CHANNELS-1:0]       loadCount;
  logic [`DMA_ADDR_WIDTH-1:0]     loadValue;
  logic [`DMA_CHANNELS-1:0]       tcFlags;
  logic [`DMA_CHANNELS-1:0]       tcReached;
  logic [`DMA_CHANNELS-1:0]       pending;
  logic [`DMA_CHANNELS-1:0]       grant;
  logic                           anyRequest;
  logic                           update;
  logic [1:0]                     servedChan;
  logic [`DMA_ADDR_WIDTH-1:0]     address;

  assign pending = dreq & ~mask & {`DMA_CHANNELS{!command.controllerDisable}};
  assign status = {pending, tcFlags};
  assign servedSetup = setup[servedChan];

  dmaRegisterFile u_regs (
    .busIf(busIf), .rstN(rstN), .cpu(cpu), .tcReached(tcReached),
    .servedChan(servedChan), .setup(setup), .mask(mask), .command(command),
    .loadAddr(loadAddr), .loadCount(loadCount), .loadValue(loadValue), .tcFlags(tcFlags)
  );

  dmaPriority u_priority (
    .busIf(busIf), .rstN(rstN), .request(pending), .rotating(command.rotatingPriority),
    .serviced(update), .servedChan(servedChan), .grant(grant), .anyRequest(anyRequest)
  );

  dmaAddressCounter u_counter (
    .busIf(busIf), .rstN(rstN), .loadAddr(loadAddr), .loadCount(loadCount),
    .loadValue(loadValue), .update(update), .servedChan(servedChan),
    .setup(servedSetup), .address(address), .tcReached(tcReached)
  );

  dmaTimingControl u_timing (
    .busIf(busIf), .rstN(rstN), .anyRequest(anyRequest), .grant(grant), .hlda(hlda),
    .setup(servedSetup), .address(address), .bus(bus), .update(update),
    .servedChan(servedChan)
  );

endmodule

//--- sim/dma_properties.sv
module dmaProperties import dmaPkg::*; (
  input logic      busIf,
  input logic      rstN,
  input logic      hlda,
  input dmaState_e state,
  input busCycle_t bus
);

  // one-hot walk SI, SO, S1, S2, S4 and back to SI
  assert property (@(posedge busIf) disable iff (!rstN) state == SI |=> state inside {SI, SO})
    else $error("state left SI for something other than SO");
  assert property (@(posedge busIf) disable iff (!rstN) state == SO |=> state inside {SO, S1})
    else $error("state left SO for something other than S1");
  assert property (@(posedge busIf) disable iff (!rstN) state == S1 |=> state == S2)
    else $error("S1 not followed by S2");
  assert property (@(posedge busIf) disable iff (!rstN) state == S2 |=> state == S4)
    else $error("S2 not followed by S4");
  assert property (@(posedge busIf) disable iff (!rstN) state == S4 |=> state == SI)
    else $error("S4 not followed by SI");

  assert property (@(posedge busIf) !rstN |=> !bus.hrq)
    else $error("hrq high right after reset");

  // address enable only once the bus has been handed over
  assert property (@(posedge busIf) disable iff (!rstN) $rose(bus.aen) |-> $past(hlda))
    else $error("aen rose without hlda");
  assert property (@(posedge busIf) disable iff (!rstN) bus.aen |-> hlda)
    else $error("aen high while hlda low");

  assert property (@(posedge busIf) disable iff (!rstN) $onehot0(bus.dack))
    else $error("more than one dack bit high");

endmodule

//--- sim/dma_tb.sv
`include "dma_settings.svh"

module dma_tb import dmaPkg::*; ();

  localparam int MaxTransfers = 72;

  typedef struct packed {
    logic [15:0] address;
    logic [3:0]  dack;
    logic [3:0]  strobes;
    logic        tc;
  } expectXfer_t;

  logic       busIf = 1'b0;
  logic       rstN;
  cpuAccess_t cpu;
  logic [3:0] dreq;
  logic       hlda;
  busCycle_t  bus;
  logic [7:0] status;

  logic [31:0] lfsrState = 32'h1ef5_0813;
  logic [31:0] hldaDelay;
  string       testName = "init";
  int          expChan[$];
  int          doneCount = 0;
  int          servedCh;
  expectXfer_t expected;

  // programmed view of each channel as the stimulus set it
  logic [15:0] cfgAddr [4];
  int          cfgCount [4];
  logic        cfgDec [4];
  logic        cfgAuto [4];
  xferType_e   cfgType [4];
  int          xferIdx [4];
  logic        tcSticky [4];

  dmaController u_dut (
    .busIf(busIf), .rstN(rstN), .cpu(cpu), .dreq(dreq), .hlda(hlda),
    .bus(bus), .status(status)
  );

  bind dmaTimingControl dmaProperties u_props (
    .busIf(busIf), .rstN(rstN), .hlda(hlda), .state(state), .bus(bus)
  );

  always #20 busIf = ~busIf;

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsrState[0]};
      lfsrState = lfsrStep(lfsrState);
    end
  endtask

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "run stopped on the first error");
  endtask

  task automatic checkValue(input string field, input logic [31:0] want, input logic [31:0] got);
    if (want !== got) begin
      failRun($sformatf("CHECK FAILED %s %s expected %0h actual %0h", testName, field, want, got));
    end
  endtask

  // expected transfer number idx of channel ch from the programmed values
  function automatic expectXfer_t refTransfer(input int ch, input int idx);
    expectXfer_t r;
    int step;
    step = cfgAuto[ch] ? idx % (cfgCount[ch] + 1) : idx;
    r.address = cfgDec[ch] ? cfgAddr[ch] - 16'(step) : cfgAddr[ch] + 16'(step);
    r.dack = 4'b0001 << ch;
    // order is iorN, iowN, memrN, memwN
    case (cfgType[ch])
      XFER_WRITE: r.strobes = 4'b0110;
      XFER_READ: r.strobes = 4'b1001;
      default: r.strobes = 4'b1111;
    endcase
    r.tc = (step == cfgCount[ch]);
    return r;
  endfunction

  task automatic cpuWrite(input logic [3:0] addr, input logic [7:0] data);
    @(negedge busIf);
    cpu = '{wrStrobe: 1'b1, addr: addr, data: data};
    @(negedge busIf);
    cpu.wrStrobe = 1'b0;
  endtask

  task automatic programChannel(input int ch, input logic [15:0] addr, input int count,
                                input logic dec, input xferType_e kind, input logic autoInit);
    cfgAddr[ch] = addr;
    cfgCount[ch] = count;
    cfgDec[ch] = dec;
    cfgAuto[ch] = autoInit;
    cfgType[ch] = kind;
    xferIdx[ch] = 0;
    tcSticky[ch] = 1'b0;
    cpuWrite(`DMA_REG_CLEAR_FF, 8'h00);
    cpuWrite(4'(2 * ch), addr[7:0]);
    cpuWrite(4'(2 * ch), addr[15:8]);
    cpuWrite(4'(2 * ch + 1), 8'(count));
    cpuWrite(4'(2 * ch + 1), 8'(count >> 8));
    cpuWrite(`DMA_REG_MODE, {2'b01, dec, autoInit, kind, 2'(ch)});
    // mask bit 2 low clears this channel's mask
    cpuWrite(`DMA_REG_MASK, {6'b0, 2'(ch)});
  endtask

  task automatic runTransfers(input logic [3:0] pattern, input int count);
    int target;
    target = doneCount + count;
    @(negedge busIf);
    dreq = pattern;
    wait (doneCount == target);
    dreq = '0;
  endtask

  task automatic expectIdle(input logic [3:0] pattern, input int cycles);
    @(negedge busIf);
    dreq = pattern;
    repeat (cycles) begin
      @(negedge busIf);
      checkValue("hrq stays low", 0, bus.hrq);
      checkValue("no pending request", 0, status[7:4]);
    end
    dreq = '0;
  endtask

  task automatic randomRun(input int ch, input logic dec);
    logic [31:0] addrBits;
    logic [31:0] countBits;
    logic [31:0] kindBits;
    int count;
    takeBits(16, addrBits);
    takeBits(3, countBits);
    takeBits(2, kindBits);
    count = countBits + 2;
    programChannel(ch, addrBits[15:0], count, dec, xferType_e'(kindBits % 3), 1'b0);
    repeat (count + 1) expChan.push_back(ch);
    runTransfers(4'b0001 << ch, count + 1);
    expectIdle(4'b0001 << ch, 8);
    checkValue("tc status", 1, status[ch]);
  endtask

  // hlda answers hrq after 0 to 3 cycles and drops with hrq
  always begin
    @(negedge busIf);
    if (bus.hrq === 1'b1 && hlda === 1'b0) begin
      takeBits(2, hldaDelay);
      repeat (hldaDelay) @(negedge busIf);
      hlda = 1'b1;
    end else if (bus.hrq !== 1'b1) begin
      hlda = 1'b0;
    end
  end

  always @(negedge busIf) begin
    if (rstN === 1'b1 && bus.aen === 1'b1) begin
      checkValue("aen only with hlda", 1, hlda);
    end
  end

  // address at ADSTB and strobes in S2 and S4, then tc in the next SI
  always begin
    @(negedge busIf);
    if (rstN === 1'b1 && bus.adstb === 1'b1) begin
      if (expChan.size() == 0) begin
        failRun("a transfer started while none was expected");
      end else begin
        servedCh = expChan.pop_front();
        expected = refTransfer(servedCh, xferIdx[servedCh]);
        checkValue("aen in S1", 1, bus.aen);
        checkValue("address", expected.address, bus.address);
        @(negedge busIf);
        checkValue("dack in S2", expected.dack, bus.dack);
        checkValue("strobes in S2", {expected.strobes[3], 1'b1, expected.strobes[1], 1'b1},
                   {bus.iorN, bus.iowN, bus.memrN, bus.memwN});
        checkValue("request in status", 1, status[4 + servedCh]);
        @(negedge busIf);
        checkValue("aen in S4", 1, bus.aen);
        checkValue("dack in S4", expected.dack, bus.dack);
        checkValue("strobes in S4", expected.strobes,
                   {bus.iorN, bus.iowN, bus.memrN, bus.memwN});
        @(negedge busIf);
        tcSticky[servedCh] = tcSticky[servedCh] | expected.tc;
        checkValue("tc flag", tcSticky[servedCh], status[servedCh]);
        xferIdx[servedCh]++;
        doneCount++;
      end
    end
  end

  // well under 20 cycles per transfer plus the programming time
  initial begin
    repeat (MaxTransfers * 20 + 600) @(posedge busIf);
    failRun("timeout: the tests did not finish in the expected time");
  end

  initial begin
    logic [31:0] rnd;
    cpu = '0;
    dreq = '0;
    hlda = 1'b0;
    rstN = 1'b0;
    repeat (5) @(negedge busIf);
    rstN = 1'b1;

    testName = "reset";
    @(negedge busIf);
    checkValue("bus idle", 11'b000_0000_1111, {bus.hrq, bus.aen, bus.adstb, bus.dack,
               bus.iorN, bus.iowN, bus.memrN, bus.memwN});
    checkValue("status", 0, status);
    expectIdle(4'b1111, 10);

    testName = "counting";
    randomRun(2, 1'b0);
    randomRun(1, 1'b1);

    testName = "transfer types";
    for (int k = 0; k < 3; k++) begin
      takeBits(16, rnd);
      programChannel(3, rnd[15:0], 1, 1'b0, xferType_e'(k), 1'b0);
      repeat (2) expChan.push_back(3);
      runTransfers(4'b1000, 2);
    end

    testName = "auto init";
    takeBits(16, rnd);
    programChannel(1, rnd[15:0], 2, rnd[0], XFER_WRITE, 1'b1);
    repeat (7) expChan.push_back(1);
    runTransfers(4'b0010, 7);

    testName = "hlda hold-off";
    for (int r = 0; r < 2; r++) begin
      takeBits(1, rnd);
      randomRun(0, rnd[0]);
    end

    testName = "fixed priority";
    cpuWrite(`DMA_REG_COMMAND, 8'h00);
    programChannel(0, 16'h1000, 1, 1'b0, XFER_READ, 1'b0);
    programChannel(1, 16'h2000, 1, 1'b0, XFER_WRITE, 1'b0);
    expChan = '{0, 0, 1, 1};
    runTransfers(4'b0011, 4);

    testName = "rotating priority";
    cpuWrite(`DMA_REG_COMMAND, 8'h10);
    for (int ch = 0; ch < 4; ch++) begin
      programChannel(ch, 16'(ch * 16'h0100), 1, 1'b0, XFER_READ, 1'b0);
    end
    expChan = '{0, 1, 2, 3, 0, 1, 2, 3};
    runTransfers(4'b1111, 8);

    $display("all tests passed");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+src
src/dmaPkg.sv
src/dmaRegisterFile.sv
src/dmaPriority.sv
src/dmaAddressCounter.sv
src/dmaTimingControl.sv
src/dmaController.sv
sim/dma_properties.sv
sim/dma_tb.sv
